// ==== Bender.yml ====
package:
  name: packet_scheduler

sources:
  - design/sched_pkg.sv
  - design/ctrl_decoder.sv
  - design/slot_keeper.sv
  - design/core_selector.sv
  - design/desc_dispatcher.sv
  - design/port_tagger.sv
  - design/packet_scheduler.sv
  - target: test
    files:
      - test/sched_checker.sv
      - test/tb_top.sv

// ==== compile.f ====
design/sched_pkg.sv
design/ctrl_decoder.sv
design/slot_keeper.sv
design/core_selector.sv
design/desc_dispatcher.sv
design/port_tagger.sv
design/packet_scheduler.sv
test/sched_checker.sv
test/tb_top.sv

// ==== design/core_selector.sv ====
`default_nettype none

module core_selector (
  input  sched_pkg::slot_count_t counts [sched_pkg::CORE_COUNT],
  input  sched_pkg::core_mask_t  core_enable,
  output sched_pkg::core_id_t    sel_core,
  output logic                   sel_valid
);

  logic                   cand_vld [sched_pkg::CORE_COUNT];
  sched_pkg::slot_count_t cand_cnt [sched_pkg::CORE_COUNT];
  sched_pkg::core_id_t    cand_id  [sched_pkg::CORE_COUNT];

  always_comb begin
    for (int i = 0; i < sched_pkg::CORE_COUNT; i++) begin
      cand_vld[i] = core_enable[i] && (counts[i] != '0);
      cand_cnt[i] = counts[i];
      cand_id[i]  = sched_pkg::core_id_t'(i);
    end

    // Pairwise tree where the lower index keeps a tie
    for (int step = 1; step < sched_pkg::CORE_COUNT; step = step * 2) begin
      for (int i = 0; i + step < sched_pkg::CORE_COUNT; i = i + 2 * step) begin
        if (cand_vld[i + step] &&
            (!cand_vld[i] || (cand_cnt[i + step] > cand_cnt[i]))) begin
          cand_vld[i] = 1'b1;
          cand_cnt[i] = cand_cnt[i + step];
          cand_id[i]  = cand_id[i + step];
        end
      end
    end

    sel_core  = cand_id[0];
    sel_valid = cand_vld[0];
  end

endmodule

`default_nettype wire

// ==== design/ctrl_decoder.sv ====
`default_nettype none

module ctrl_decoder (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  ctrl_valid,
  input  sched_pkg::ctrl_msg_t  ctrl_msg,
  output sched_pkg::core_mask_t init_strb,
  output sched_pkg::core_mask_t rel_strb,
  output sched_pkg::slot_t      slot_val
);

  sched_pkg::core_mask_t core_sel;

  assign core_sel = sched_pkg::core_mask_t'(1) << ctrl_msg.core;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_strb <= '0;
      rel_strb  <= '0;
    end else begin
      init_strb <= '0;
      rel_strb  <= '0;
      if (ctrl_valid) begin
        case (ctrl_msg.msg_type)
          sched_pkg::MSG_SLOT_INIT:    init_strb <= core_sel;
          sched_pkg::MSG_SLOT_RELEASE: rel_strb  <= core_sel;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_valid) begin
      slot_val <= ctrl_msg.slot;
    end
  end

endmodule

`default_nettype wire

// ==== design/desc_dispatcher.sv ====
`default_nettype none

module desc_dispatcher (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  desc_req [sched_pkg::PORT_COUNT],
  input  sched_pkg::core_id_t   sel_core,
  input  logic                  sel_valid,
  input  sched_pkg::slot_t      heads [sched_pkg::CORE_COUNT],
  output sched_pkg::core_mask_t pop,
  output logic                  desc_load [sched_pkg::PORT_COUNT],
  output sched_pkg::desc_t      desc
);

  sched_pkg::port_id_t last_grant;
  sched_pkg::port_id_t grant_idx;
  logic                grant_found;
  logic                fire;
  int                  cand;

  // Search starts one past the last granted port
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = last_grant;
    cand        = 0;
    for (int k = 1; k <= sched_pkg::PORT_COUNT; k++) begin
      cand = (int'(last_grant) + k) % sched_pkg::PORT_COUNT;
      if (!grant_found && desc_req[cand]) begin
        grant_found = 1'b1;
        grant_idx   = sched_pkg::port_id_t'(cand);
      end
    end
  end

  // Counts lag a pop by one cycle so hold off while one is out
  assign fire = sel_valid && grant_found && (pop == '0);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      last_grant <= '0;
      pop        <= '0;
      for (int p = 0; p < sched_pkg::PORT_COUNT; p++) begin
        desc_load[p] <= 1'b0;
      end
    end else begin
      pop <= fire ? (sched_pkg::core_mask_t'(1) << sel_core) : '0;
      for (int p = 0; p < sched_pkg::PORT_COUNT; p++) begin
        desc_load[p] <= fire && (grant_idx == sched_pkg::port_id_t'(p));
      end
      if (fire) begin
        last_grant <= grant_idx;
      end
    end
  end

  // Head stays put until the pop lands
  always_ff @(posedge clk) begin
    if (fire) begin
      desc.core <= sel_core;
      desc.slot <= heads[sel_core];
    end
  end

endmodule

`default_nettype wire

// ==== design/packet_scheduler.sv ====
`default_nettype none

module packet_scheduler (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  ctrl_valid,
  input  sched_pkg::ctrl_msg_t  ctrl_msg,
  input  sched_pkg::core_mask_t core_enable,
  output logic                  slot_err,
  input  logic                  rx_valid [sched_pkg::PORT_COUNT],
  input  sched_pkg::beat_t      rx_beat  [sched_pkg::PORT_COUNT],
  output logic                  rx_ready [sched_pkg::PORT_COUNT],
  output logic                  tx_valid [sched_pkg::PORT_COUNT],
  output sched_pkg::beat_t      tx_beat  [sched_pkg::PORT_COUNT],
  input  logic                  tx_ready [sched_pkg::PORT_COUNT],
  output sched_pkg::desc_t      tx_dest  [sched_pkg::PORT_COUNT],
  output sched_pkg::port_id_t   tx_port  [sched_pkg::PORT_COUNT]
);

  sched_pkg::core_mask_t  init_strb;
  sched_pkg::core_mask_t  rel_strb;
  sched_pkg::slot_t       slot_val;
  sched_pkg::slot_t       heads  [sched_pkg::CORE_COUNT];
  sched_pkg::slot_count_t counts [sched_pkg::CORE_COUNT];
  sched_pkg::core_mask_t  enq_err;
  sched_pkg::core_mask_t  pop;
  sched_pkg::core_id_t    sel_core;
  logic                   sel_valid;
  logic                   desc_req  [sched_pkg::PORT_COUNT];
  logic                   desc_load [sched_pkg::PORT_COUNT];
  sched_pkg::desc_t       desc;

  assign slot_err = |enq_err;

  ctrl_decoder ctrl_decoder_i (
    .clk       (clk),
    .rst_r     (rst_r),
    .ctrl_valid(ctrl_valid),
    .ctrl_msg  (ctrl_msg),
    .init_strb (init_strb),
    .rel_strb  (rel_strb),
    .slot_val  (slot_val)
  );

  for (genvar c = 0; c < sched_pkg::CORE_COUNT; c++) begin : g_core
    slot_keeper slot_keeper_i (
      .clk         (clk),
      .rst_r       (rst_r),
      .init        (init_strb[c]),
      .release_slot(rel_strb[c]),
      .slot_in     (slot_val),
      .pop         (pop[c]),
      .head        (heads[c]),
      .head_valid  (),
      .count       (counts[c]),
      .enq_err     (enq_err[c])
    );
  end

  core_selector core_selector_i (
    .counts     (counts),
    .core_enable(core_enable),
    .sel_core   (sel_core),
    .sel_valid  (sel_valid)
  );

  desc_dispatcher desc_dispatcher_i (
    .clk      (clk),
    .rst_r    (rst_r),
    .desc_req (desc_req),
    .sel_core (sel_core),
    .sel_valid(sel_valid),
    .heads    (heads),
    .pop      (pop),
    .desc_load(desc_load),
    .desc     (desc)
  );

  for (genvar p = 0; p < sched_pkg::PORT_COUNT; p++) begin : g_port
    assign tx_port[p] = sched_pkg::port_id_t'(p);

    port_tagger port_tagger_i (
      .clk      (clk),
      .rst_r    (rst_r),
      .desc_load(desc_load[p]),
      .desc     (desc),
      .desc_req (desc_req[p]),
      .rx_valid (rx_valid[p]),
      .rx_beat  (rx_beat[p]),
      .rx_ready (rx_ready[p]),
      .tx_valid (tx_valid[p]),
      .tx_beat  (tx_beat[p]),
      .tx_ready (tx_ready[p]),
      .tx_dest  (tx_dest[p])
    );
  end

endmodule

`default_nettype wire

// ==== design/port_tagger.sv ====
`default_nettype none

module port_tagger (
  input  logic              clk,
  input  logic              rst_r,
  input  logic              desc_load,
  input  sched_pkg::desc_t  desc,
  output logic              desc_req,
  input  logic              rx_valid,
  input  sched_pkg::beat_t  rx_beat,
  output logic              rx_ready,
  output logic              tx_valid,
  output sched_pkg::beat_t  tx_beat,
  input  logic              tx_ready,
  output sched_pkg::desc_t  tx_dest
);

  sched_pkg::port_state_t state;
  sched_pkg::desc_t       next_desc;
  sched_pkg::desc_t       cur_desc;
  logic                   not_stall;
  logic                   beat_xfer;
  logic                   last_xfer;

  assign not_stall = (state != sched_pkg::PS_STALL);
  assign rx_ready  = tx_ready && not_stall;
  assign tx_valid  = rx_valid && not_stall;
  assign tx_beat   = rx_beat;
  assign beat_xfer = rx_valid && rx_ready;
  assign last_xfer = beat_xfer && rx_beat.last;

  // First beat takes the fresh descriptor directly
  assign tx_dest = (state == sched_pkg::PS_FIRST) ? next_desc : cur_desc;

  assign desc_req = !desc_load &&
                    ((state == sched_pkg::PS_STALL) || (state == sched_pkg::PS_WAIT) ||
                     ((state == sched_pkg::PS_FIRST) && beat_xfer));

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state <= sched_pkg::PS_STALL;
    end else begin
      case (state)
        sched_pkg::PS_STALL: if (desc_load) state <= sched_pkg::PS_FIRST;
        sched_pkg::PS_FIRST: begin
          if (last_xfer) state <= sched_pkg::PS_STALL;
          else if (beat_xfer) state <= sched_pkg::PS_WAIT;
        end
        sched_pkg::PS_WAIT: begin
          if (desc_load && last_xfer) state <= sched_pkg::PS_FIRST;
          else if (desc_load) state <= sched_pkg::PS_MID;
          else if (last_xfer) state <= sched_pkg::PS_STALL;
        end
        sched_pkg::PS_MID: if (last_xfer) state <= sched_pkg::PS_FIRST;
        default: state <= sched_pkg::PS_STALL;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (desc_load) begin
      next_desc <= desc;
    end
    if ((state == sched_pkg::PS_FIRST) && beat_xfer) begin
      cur_desc <= next_desc;
    end
  end

endmodule

`default_nettype wire

// ==== design/sched_pkg.sv ====
`default_nettype none

package sched_pkg;

  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 8;
  localparam int PORT_COUNT = 2;
  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = 8;

  typedef logic [1:0]            core_id_t;
  // Slot numbers run from 1 and 0 means none
  typedef logic [3:0]            slot_t;
  typedef logic [3:0]            slot_count_t;
  typedef logic [0:0]            port_id_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [KEEP_WIDTH-1:0] keep_t;
  typedef logic [CORE_COUNT-1:0] core_mask_t;

  typedef enum logic [3:0] {
    MSG_SLOT_RELEASE = 4'd0,
    MSG_SLOT_INIT    = 4'd3
  } msg_type_t;

  typedef enum logic [1:0] {
    PS_STALL = 2'b00,
    PS_FIRST = 2'b01,
    PS_WAIT  = 2'b10,
    PS_MID   = 2'b11
  } port_state_t;

  // Slot field holds the slot count on an init message
  typedef struct packed {
    msg_type_t msg_type;
    core_id_t  core;
    slot_t     slot;
  } ctrl_msg_t;

  typedef struct packed {
    core_id_t core;
    slot_t    slot;
  } desc_t;

  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
  } beat_t;

endpackage

`default_nettype wire

// ==== design/slot_keeper.sv ====
`default_nettype none

module slot_keeper (
  input  logic                   clk,
  input  logic                   rst_r,
  input  logic                   init,
  input  logic                   release_slot,
  input  sched_pkg::slot_t       slot_in,
  input  logic                   pop,
  output sched_pkg::slot_t       head,
  output logic                   head_valid,
  output sched_pkg::slot_count_t count,
  output logic                   enq_err
);

  sched_pkg::slot_t                         mem [sched_pkg::SLOT_COUNT];
  logic [$clog2(sched_pkg::SLOT_COUNT)-1:0] rd_ptr;
  logic [$clog2(sched_pkg::SLOT_COUNT)-1:0] wr_ptr;
  sched_pkg::slot_count_t                   cap;
  sched_pkg::slot_count_t                   init_n;
  logic                                     full;
  logic                                     push;
  logic                                     take;

  // Init count clamped to FIFO depth
  assign init_n = (slot_in > sched_pkg::SLOT_COUNT) ?
                  sched_pkg::slot_count_t'(sched_pkg::SLOT_COUNT) : slot_in;

  // Full once every slot handed out at init is back
  assign full       = (count == cap);
  assign push       = release_slot && !full;
  assign take       = pop && head_valid;
  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);

  always_ff @(posedge clk) begin
    if (init) begin
      for (int i = 0; i < sched_pkg::SLOT_COUNT; i++) begin
        mem[i] <= sched_pkg::slot_t'(i + 1);
      end
    end else if (push) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count   <= '0;
      cap     <= '0;
      enq_err <= 1'b0;
    end else if (init) begin
      rd_ptr  <= '0;
      wr_ptr  <= init_n[$bits(wr_ptr)-1:0];
      count   <= init_n;
      cap     <= init_n;
      enq_err <= 1'b0;
    end else begin
      enq_err <= release_slot && full;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== test/sched_checker.sv ====
`default_nettype none

module sched_checker (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  ctrl_valid,
  input  sched_pkg::ctrl_msg_t  ctrl_msg,
  input  sched_pkg::core_mask_t core_enable,
  input  logic                  slot_err,
  input  logic                  rx_valid [sched_pkg::PORT_COUNT],
  input  sched_pkg::beat_t      rx_beat  [sched_pkg::PORT_COUNT],
  input  logic                  rx_ready [sched_pkg::PORT_COUNT],
  input  logic                  tx_valid [sched_pkg::PORT_COUNT],
  input  sched_pkg::beat_t      tx_beat  [sched_pkg::PORT_COUNT],
  input  logic                  tx_ready [sched_pkg::PORT_COUNT],
  input  sched_pkg::desc_t      tx_dest  [sched_pkg::PORT_COUNT],
  input  sched_pkg::port_id_t   tx_port  [sched_pkg::PORT_COUNT],
  input  logic                  end_of_test,
  output int                    packets_seen,
  output int                    error_count,
  output logic                  report_done
);
  timeunit 1ns;
  timeprecision 1ps;

  // Bit s set means slot s is free on that core
  logic [sched_pkg::SLOT_COUNT:1] free_set [sched_pkg::CORE_COUNT];
  int                             init_cnt [sched_pkg::CORE_COUNT];
  sched_pkg::beat_t               exp_q    [sched_pkg::PORT_COUNT][$];
  logic                           in_pkt   [sched_pkg::PORT_COUNT];
  sched_pkg::desc_t               pkt_tag  [sched_pkg::PORT_COUNT];
  logic [1:0]                     err_pipe;
  logic                           init_seen;
  int                             data_errs = 0;
  int                             tag_errs = 0;
  int                             flag_errs = 0;

  task value_error(input string test, input logic [127:0] expected, input logic [127:0] actual);
    $display("** Error: %s expected %0h actual %0h at %0t", test, expected, actual, $time);
  endtask

  task automatic start_packet(input int p);
    sched_pkg::desc_t tag;
    logic             any_free;
    tag      = tx_dest[p];
    any_free = 1'b0;
    for (int c = 0; c < sched_pkg::CORE_COUNT; c++) begin
      if (core_enable[c] && (free_set[c] != '0)) any_free = 1'b1;
    end
    if (!any_free) begin
      tag_errs++;
      $display("Error: port %0d started a packet while no slot was free", p);
    end else if (!core_enable[tag.core]) begin
      tag_errs++;
      $display("Error: port %0d tagged a packet for disabled core %0d", p, tag.core);
    end else if ((tag.slot == '0) || (tag.slot > sched_pkg::SLOT_COUNT) ||
                 !free_set[tag.core][tag.slot]) begin
      tag_errs++;
      $display("Error: port %0d used slot %0d of core %0d which is not free", p, tag.slot,
               tag.core);
    end else begin
      free_set[tag.core][tag.slot] = 1'b0;
    end
    pkt_tag[p] = tag;
  endtask

  task automatic check_port(input int p);
    sched_pkg::beat_t exp;
    if (!init_seen && (tx_valid[p] || rx_ready[p])) begin
      flag_errs++;
      $display("Error: port %0d was active before any slot init", p);
    end
    if (rx_valid[p] && rx_ready[p]) exp_q[p].push_back(rx_beat[p]);
    if (tx_valid[p] && tx_ready[p]) begin
      if (exp_q[p].size() == 0) begin
        data_errs++;
        $display("Error: port %0d sent a beat that never entered it", p);
      end else begin
        exp = exp_q[p].pop_front();
        if (tx_beat[p] !== exp) begin
          data_errs++;
          value_error($sformatf("beat order port %0d", p), exp, tx_beat[p]);
        end
      end
      // Each port reports its own index
      if (tx_port[p] !== p) begin
        tag_errs++;
        value_error($sformatf("port index port %0d", p), p, tx_port[p]);
      end
      if (!in_pkt[p]) begin
        start_packet(p);
      end else if (tx_dest[p] !== pkt_tag[p]) begin
        tag_errs++;
        value_error($sformatf("tag hold port %0d", p), pkt_tag[p], tx_dest[p]);
      end
      in_pkt[p] = !tx_beat[p].last;
      if (tx_beat[p].last) packets_seen++;
    end
  endtask

  // Error pulse lands two cycles after the message
  task automatic update_slot_model();
    logic expect_err;
    int   c;
    int   n;
    expect_err = 1'b0;
    if (slot_err !== err_pipe[1]) begin
      flag_errs++;
      value_error("slot_err pulse", err_pipe[1], slot_err);
    end
    if (ctrl_valid) begin
      c = ctrl_msg.core;
      case (ctrl_msg.msg_type)
        sched_pkg::MSG_SLOT_INIT: begin
          init_seen   = 1'b1;
          n           = (ctrl_msg.slot > sched_pkg::SLOT_COUNT) ? sched_pkg::SLOT_COUNT :
                        ctrl_msg.slot;
          init_cnt[c] = n;
          free_set[c] = '0;
          for (int s = 1; s <= n; s++) free_set[c][s] = 1'b1;
        end
        sched_pkg::MSG_SLOT_RELEASE: begin
          if ($countones(free_set[c]) == init_cnt[c]) expect_err = 1'b1;
          else free_set[c][ctrl_msg.slot] = 1'b1;
        end
        default: ;
      endcase
    end
    err_pipe = {err_pipe[0], expect_err};
  endtask

  always @(negedge clk) begin
    if (rst_r) begin
      err_pipe     = '0;
      init_seen    = 1'b0;
      packets_seen = 0;
      report_done  = 1'b0;
      for (int c = 0; c < sched_pkg::CORE_COUNT; c++) begin
        free_set[c] = '0;
        init_cnt[c] = 0;
      end
      for (int p = 0; p < sched_pkg::PORT_COUNT; p++) begin
        in_pkt[p] = 1'b0;
        exp_q[p].delete();
      end
    end else begin
      for (int p = 0; p < sched_pkg::PORT_COUNT; p++) check_port(p);
      update_slot_model();
      if (end_of_test && !report_done) begin
        for (int p = 0; p < sched_pkg::PORT_COUNT; p++) begin
          if (exp_q[p].size() != 0) begin
            data_errs++;
            $display("Error: port %0d holds %0d beats that never left", p, exp_q[p].size());
          end
        end
        $display("Error counts: data %0d, tag %0d, status %0d", data_errs, tag_errs, flag_errs);
        error_count = data_errs + tag_errs + flag_errs;
        report_done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_top.sv ====
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int  PKTS_PER_PORT   = 200;
  localparam int  TOTAL_PKTS      = PKTS_PER_PORT * sched_pkg::PORT_COUNT;
  localparam int  WATCHDOG_CYCLES = TOTAL_PKTS * 6 * 20;
  localparam time DRIVE_DELAY     = 10ns;

  typedef struct packed {
    int               due;
    sched_pkg::desc_t tag;
  } release_t;

  logic                  clk;
  logic                  rst_r;
  logic                  ctrl_valid;
  sched_pkg::ctrl_msg_t  ctrl_msg;
  sched_pkg::core_mask_t core_enable;
  logic                  slot_err;
  logic                  rx_valid [sched_pkg::PORT_COUNT];
  sched_pkg::beat_t      rx_beat  [sched_pkg::PORT_COUNT];
  logic                  rx_ready [sched_pkg::PORT_COUNT];
  logic                  tx_valid [sched_pkg::PORT_COUNT];
  sched_pkg::beat_t      tx_beat  [sched_pkg::PORT_COUNT];
  logic                  tx_ready [sched_pkg::PORT_COUNT];
  sched_pkg::desc_t      tx_dest  [sched_pkg::PORT_COUNT];
  sched_pkg::port_id_t   tx_port  [sched_pkg::PORT_COUNT];
  logic                  end_of_test;
  logic                  report_done;
  int                    packets_seen;
  int                    error_count;
  int                    cycle = 0;
  release_t              pending [$];

  packet_scheduler packet_scheduler_i (.*);
  sched_checker    sched_checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task step_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic send_ctrl(input sched_pkg::msg_type_t t, input sched_pkg::core_id_t c,
                           input sched_pkg::slot_t s);
    ctrl_valid        = 1'b1;
    ctrl_msg.msg_type = t;
    ctrl_msg.core     = c;
    ctrl_msg.slot     = s;
    step_cycle();
    ctrl_valid = 1'b0;
  endtask

  task automatic run_control();
    int       found;
    release_t entry;
    repeat (20) step_cycle();
    for (int c = 0; c < sched_pkg::CORE_COUNT; c++) begin
      send_ctrl(sched_pkg::MSG_SLOT_INIT, c, sched_pkg::slot_t'(1 + $urandom % 8));
    end
    // Core 3 is never selected so its FIFO is still full
    send_ctrl(sched_pkg::MSG_SLOT_RELEASE, 2'd3, 4'd1);
    forever begin
      found = -1;
      foreach (pending[i]) if ((found < 0) && (pending[i].due <= cycle)) found = i;
      if (found >= 0) begin
        entry = pending[found];
        pending.delete(found);
        send_ctrl(sched_pkg::MSG_SLOT_RELEASE, entry.tag.core, entry.tag.slot);
      end else begin
        step_cycle();
      end
    end
  endtask

  // A core hands its slot back some time after the last beat
  task automatic watch_departures();
    release_t entry;
    forever begin
      @(negedge clk);
      for (int p = 0; p < sched_pkg::PORT_COUNT; p++) begin
        if (tx_valid[p] && tx_ready[p] && tx_beat[p].last) begin
          entry.due = cycle + 5 + int'($urandom % 26);
          entry.tag = tx_dest[p];
          pending.push_back(entry);
        end
      end
    end
  endtask

  task automatic run_ready(input int p);
    forever begin
      tx_ready[p] = ($urandom % 4) != 0;
      step_cycle();
    end
  endtask

  task automatic port_traffic(input int p);
    int   len;
    logic accepted;
    for (int n = 0; n < PKTS_PER_PORT; n++) begin
      len = 1 + $urandom % 6;
      repeat ($urandom % 4) step_cycle();
      for (int b = 0; b < len; b++) begin
        rx_valid[p]     = 1'b1;
        rx_beat[p].data = {$urandom, $urandom};
        rx_beat[p].keep = 8'hff >> ($urandom % 8);
        rx_beat[p].last = (b == len - 1);
        accepted        = 1'b0;
        while (!accepted) begin
          @(negedge clk);
          accepted = rx_ready[p];
          step_cycle();
        end
      end
      rx_valid[p] = 1'b0;
    end
  endtask

  initial begin
    void'($urandom(4));
    rst_r       = 1'b1;
    ctrl_valid  = 1'b0;
    ctrl_msg    = '0;
    core_enable = 4'b0111;
    end_of_test = 1'b0;
    for (int p = 0; p < sched_pkg::PORT_COUNT; p++) begin
      rx_valid[p] = 1'b0;
      rx_beat[p]  = '0;
      tx_ready[p] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #DRIVE_DELAY;
    rst_r = 1'b0;
    fork
      run_control();
      watch_departures();
      run_ready(0);
      run_ready(1);
      port_traffic(0);
      port_traffic(1);
    join_none
    wait (packets_seen == TOTAL_PKTS);
    repeat (8) step_cycle();
    end_of_test = 1'b1;
    wait (report_done);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: only %0d of %0d packets left the DUT within %0d cycles",
             packets_seen, TOTAL_PKTS, WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
